// ==== src/pla_reflow_pkg.sv ====
package pla_reflow_pkg;

	// slice id, split into table slot and tag
	localparam int SLICE_ID_W   = 15;
	localparam int SLOT_W       = 14;
	localparam int TAG_W        = 1;
	localparam int DATA_W       = 32;

	// slice store burst and read timing
	localparam int BURST_WORDS  = 64;
	localparam int BURST_CNT_W  = $clog2(BURST_WORDS);
	localparam int RD_LATENCY   = 7;
	localparam int READ_TIMEOUT = 3840;
	localparam int WAIT_W       = $clog2(READ_TIMEOUT + 1);

	// output FIFO and downstream credits
	localparam int FIFO_DEPTH       = 512;
	localparam int FIFO_AW          = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W       = FIFO_AW + 1;
	localparam int FIFO_AFULL_LEVEL = 256;
	localparam int CREDIT_INIT      = 8;
	localparam int CREDIT_W         = 4;
	localparam int ERR_CNT_W        = 16;

	typedef logic [SLICE_ID_W-1:0] slice_id_t;
	typedef logic [SLOT_W-1:0]     slot_t;
	typedef logic [TAG_W-1:0]      tag_t;
	typedef logic [DATA_W-1:0]     data_word_t;
	typedef logic [ERR_CNT_W-1:0]  err_cnt_t;

	typedef enum logic {IDLE, READ} reflow_state_t;

endpackage

// ==== src/pla_reflow_bus_pkg.sv ====
package pla_reflow_bus_pkg;

	// one pulse per arrived slice id
	typedef struct packed
	{
		logic                      valid;
		pla_reflow_pkg::slice_id_t id;
	} slice_new_t;

	// table answer, tagged with the id it was looked up for
	typedef struct packed
	{
		logic                      valid;
		pla_reflow_pkg::slice_id_t id;
		logic                      present;
	} lookup_rsp_t;

	// read request to the slice store, also the table claim
	typedef struct packed
	{
		logic                      req;
		pla_reflow_pkg::slice_id_t id;
	} store_req_t;

	typedef struct packed
	{
		logic                       resp;
		pla_reflow_pkg::data_word_t rdata;
	} store_rsp_t;

	// downstream beat
	typedef struct packed
	{
		logic                       valid;
		pla_reflow_pkg::data_word_t data;
	} out_beat_t;

endpackage

// ==== src/slice_valid_table.sv ====
`timescale 1ns/100ps
module slice_valid_table
(
	input  logic                            I_pla_312m5_clk,
	input  logic                            I_pla_rst,
	input  pla_reflow_bus_pkg::slice_new_t  slice_new,
	input  pla_reflow_bus_pkg::store_req_t  claim,
	input  pla_reflow_pkg::slice_id_t       cur_id,
	output pla_reflow_bus_pkg::lookup_rsp_t lookup
);

	typedef struct packed
	{
		pla_reflow_pkg::tag_t tag;
		logic                 present;
	} entry_t;

	entry_t                         tag_mem [2**pla_reflow_pkg::SLOT_W];
	pla_reflow_bus_pkg::store_req_t claim_q;
	pla_reflow_pkg::slot_t          new_slot;
	pla_reflow_pkg::slot_t          cur_slot;
	pla_reflow_pkg::slot_t          claim_slot;
	logic                           wr_en;
	pla_reflow_pkg::slot_t          wr_slot;
	entry_t                         wr_entry;
	logic                           rd_vld;
	pla_reflow_pkg::slice_id_t      rd_id;
	entry_t                         rd_entry;

	assign new_slot   = slice_new.id[pla_reflow_pkg::SLOT_W-1:0];
	assign cur_slot   = cur_id[pla_reflow_pkg::SLOT_W-1:0];
	assign claim_slot = claim_q.id[pla_reflow_pkg::SLOT_W-1:0];

	// --------------------------------------------------
	// write side
	// --------------------------------------------------

	// claim waits here while arrivals own the write port
	always_ff @(posedge I_pla_312m5_clk)
	begin
		if (I_pla_rst)
			claim_q.req <= 1'b0;
		else if (claim.req)
			claim_q <= claim;
		else if (!slice_new.valid || new_slot == claim_slot)
			claim_q.req <= 1'b0;
	end

	// arrival first, then the pending claim
	always_comb
	begin
		wr_en    = 1'b0;
		wr_slot  = new_slot;
		wr_entry = {slice_new.id[pla_reflow_pkg::SLICE_ID_W-1:pla_reflow_pkg::SLOT_W], 1'b1};
		if (slice_new.valid)
			wr_en = 1'b1;
		else if (claim_q.req)
		begin
			wr_en    = 1'b1;
			wr_slot  = claim_slot;
			wr_entry = {claim_q.id[pla_reflow_pkg::SLICE_ID_W-1:pla_reflow_pkg::SLOT_W], 1'b0};
		end
	end

	always_ff @(posedge I_pla_312m5_clk)
	begin
		if (wr_en)
			tag_mem[wr_slot] <= wr_entry;
	end

	// --------------------------------------------------
	// lookup, two stages
	// --------------------------------------------------

	always_ff @(posedge I_pla_312m5_clk)
	begin
		rd_id <= cur_id;
		// same cycle write wins over the stored entry
		if (wr_en && wr_slot == cur_slot)
			rd_entry <= wr_entry;
		else
			rd_entry <= tag_mem[cur_slot];
	end

	always_ff @(posedge I_pla_312m5_clk)
	begin
		if (I_pla_rst)
		begin
			rd_vld <= 1'b0;
			lookup <= '0;
		end
		else
		begin
			rd_vld         <= 1'b1;
			lookup.valid   <= rd_vld;
			lookup.id      <= rd_id;
			lookup.present <= rd_entry.present &&
				(rd_entry.tag == rd_id[pla_reflow_pkg::SLICE_ID_W-1:pla_reflow_pkg::SLOT_W]);
		end
	end

endmodule

// ==== src/reflow_sequencer.sv ====
`timescale 1ns/100ps
module reflow_sequencer
(
	input  logic                            I_pla_312m5_clk,
	input  logic                            I_pla_rst,
	input  pla_reflow_bus_pkg::lookup_rsp_t lookup,
	input  logic                            fifo_afull,
	input  logic                            store_rsp_resp,
	input  logic                            cnt_clear,
	output pla_reflow_pkg::slice_id_t       cur_id,
	output pla_reflow_bus_pkg::store_req_t  store_req,
	output pla_reflow_pkg::err_cnt_t        rderr_cnt
);

	typedef logic [pla_reflow_pkg::WAIT_W-1:0] wait_cnt_t;

	pla_reflow_pkg::reflow_state_t state;
	wait_cnt_t                     wait_cnt;
	logic                          resp_q;
	logic                          resp_rise;
	logic                          slice_ready;
	logic                          timed_out;

	assign resp_rise = store_rsp_resp && !resp_q;
	assign timed_out = (wait_cnt == wait_cnt_t'(pla_reflow_pkg::READ_TIMEOUT));

	// stale answers for earlier ids are ignored
	assign slice_ready = lookup.valid && lookup.present && (lookup.id == cur_id) && !fifo_afull;

	always_ff @(posedge I_pla_312m5_clk)
	begin
		if (I_pla_rst)
			resp_q <= 1'b0;
		else
			resp_q <= store_rsp_resp;
	end

	// --------------------------------------------------
	// in-order walker
	// --------------------------------------------------

	always_ff @(posedge I_pla_312m5_clk)
	begin
		if (I_pla_rst)
		begin
			state         <= pla_reflow_pkg::IDLE;
			cur_id        <= '0;
			wait_cnt      <= '0;
			store_req.req <= 1'b0;
		end
		else
		begin
			store_req.req <= 1'b0;
			case (state)
				pla_reflow_pkg::IDLE:
				begin
					wait_cnt <= '0;
					if (slice_ready)
					begin
						store_req.req <= 1'b1;
						store_req.id  <= cur_id;
						cur_id        <= cur_id + 1'b1;
						state         <= pla_reflow_pkg::READ;
					end
				end
				pla_reflow_pkg::READ:
				begin
					// hold the slot until the store is ready or gives up
					if (resp_rise || timed_out)
						state <= pla_reflow_pkg::IDLE;
					if (!timed_out)
						wait_cnt <= wait_cnt + 1'b1;
				end
				default:
				begin
					state <= pla_reflow_pkg::IDLE;
				end
			endcase
		end
	end

	// one count per timed-out slice
	always_ff @(posedge I_pla_312m5_clk)
	begin
		if (I_pla_rst || cnt_clear)
			rderr_cnt <= '0;
		else if (state == pla_reflow_pkg::READ && timed_out && !resp_rise)
			rderr_cnt <= rderr_cnt + 1'b1;
	end

endmodule

// ==== src/slice_burst_capture.sv ====
`timescale 1ns/100ps
module slice_burst_capture
(
	input  logic                           I_pla_312m5_clk,
	input  logic                           I_pla_rst,
	input  pla_reflow_bus_pkg::store_rsp_t store_rsp,
	output logic                           data_rd,
	output logic                           fifo_wr,
	output pla_reflow_pkg::data_word_t     fifo_wdata
);

	typedef logic [pla_reflow_pkg::BURST_CNT_W-1:0] burst_cnt_t;

	logic                                  resp_q;
	burst_cnt_t                            burst_cnt;
	logic [pla_reflow_pkg::RD_LATENCY-1:0] cap_pipe;

	// strobe burst, started by the rising edge of resp
	always_ff @(posedge I_pla_312m5_clk)
	begin
		if (I_pla_rst)
		begin
			resp_q    <= 1'b0;
			data_rd   <= 1'b0;
			burst_cnt <= '0;
		end
		else
		begin
			resp_q <= store_rsp.resp;
			if (data_rd)
			begin
				burst_cnt <= burst_cnt + 1'b1;
				if (burst_cnt == burst_cnt_t'(pla_reflow_pkg::BURST_WORDS - 1))
					data_rd <= 1'b0;
			end
			else if (store_rsp.resp && !resp_q)
			begin
				data_rd   <= 1'b1;
				burst_cnt <= '0;
			end
		end
	end

	// strobe delayed to line up with rdata
	always_ff @(posedge I_pla_312m5_clk)
	begin
		if (I_pla_rst)
		begin
			cap_pipe <= '0;
			fifo_wr  <= 1'b0;
		end
		else
		begin
			cap_pipe <= {cap_pipe[pla_reflow_pkg::RD_LATENCY-2:0], data_rd};
			fifo_wr  <= cap_pipe[pla_reflow_pkg::RD_LATENCY-1];
		end
	end

	always_ff @(posedge I_pla_312m5_clk)
	begin
		if (cap_pipe[pla_reflow_pkg::RD_LATENCY-1])
			fifo_wdata <= store_rsp.rdata;
	end

endmodule

// ==== src/reflow_out_fifo.sv ====
`timescale 1ns/100ps
module reflow_out_fifo
(
	input  logic                          I_pla_312m5_clk,
	input  logic                          I_pla_rst,
	input  logic                          fifo_wr,
	input  pla_reflow_pkg::data_word_t    fifo_wdata,
	input  logic                          credit_return,
	output pla_reflow_bus_pkg::out_beat_t out,
	output logic                          fifo_afull
);

	typedef logic [pla_reflow_pkg::FIFO_AW-1:0]    fifo_ptr_t;
	typedef logic [pla_reflow_pkg::FIFO_CNT_W-1:0] fifo_cnt_t;
	typedef logic [pla_reflow_pkg::CREDIT_W-1:0]   credit_t;

	pla_reflow_pkg::data_word_t fifo_mem [pla_reflow_pkg::FIFO_DEPTH];
	fifo_ptr_t                  wr_ptr;
	fifo_ptr_t                  rd_ptr;
	fifo_cnt_t                  fill;
	credit_t                    credits;
	logic                       pop;
	pla_reflow_pkg::data_word_t head_word;

	// pop only with a word at hand and a credit left
	assign pop = ((fill != '0) || fifo_wr) && (credits != '0);

	// an empty FIFO hands the incoming word straight through
	assign head_word = (fill == '0) ? fifo_wdata : fifo_mem[rd_ptr];

	always_ff @(posedge I_pla_312m5_clk)
	begin
		if (fifo_wr)
			fifo_mem[wr_ptr] <= fifo_wdata;
	end

	// --------------------------------------------------
	// pointers, fill level, almost full
	// --------------------------------------------------

	always_ff @(posedge I_pla_312m5_clk)
	begin
		if (I_pla_rst)
		begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fill       <= '0;
			fifo_afull <= 1'b0;
		end
		else
		begin
			if (fifo_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (fifo_wr && !pop)
				fill <= fill + 1'b1;
			else if (!fifo_wr && pop)
				fill <= fill - 1'b1;
			fifo_afull <= (fill >= fifo_cnt_t'(pla_reflow_pkg::FIFO_AFULL_LEVEL));
		end
	end

	// --------------------------------------------------
	// credits and delivery
	// --------------------------------------------------

	always_ff @(posedge I_pla_312m5_clk)
	begin
		if (I_pla_rst)
		begin
			credits   <= credit_t'(pla_reflow_pkg::CREDIT_INIT);
			out.valid <= 1'b0;
		end
		else
		begin
			out.valid <= pop;
			if (credit_return && !pop)
				credits <= credits + 1'b1;
			else if (!credit_return && pop)
				credits <= credits - 1'b1;
		end
	end

	always_ff @(posedge I_pla_312m5_clk)
	begin
		if (pop)
			out.data <= head_word;
	end

endmodule

// ==== src/pla_backward_reflow.sv ====
`timescale 1ns/100ps
module pla_backward_reflow
(
	input  logic                           I_pla_312m5_clk,
	input  logic                           I_pla_rst,
	input  pla_reflow_bus_pkg::slice_new_t slice_new,
	input  pla_reflow_bus_pkg::store_rsp_t store_rsp,
	input  logic                           credit_return,
	input  logic                           cnt_clear,
	output pla_reflow_bus_pkg::store_req_t store_req,
	output logic                           data_rd,
	output pla_reflow_bus_pkg::out_beat_t  out,
	output pla_reflow_pkg::err_cnt_t       rderr_cnt
);

	pla_reflow_bus_pkg::lookup_rsp_t lookup;
	pla_reflow_pkg::slice_id_t       cur_id;
	logic                            fifo_afull;
	logic                            fifo_wr;
	pla_reflow_pkg::data_word_t      fifo_wdata;

	// input side, arrivals and claims
	slice_valid_table u_slice_valid_table
	(
		.I_pla_312m5_clk (I_pla_312m5_clk),
		.I_pla_rst       (I_pla_rst),
		.slice_new       (slice_new),
		.claim           (store_req),
		.cur_id          (cur_id),
		.lookup          (lookup)
	);

	reflow_sequencer u_reflow_sequencer
	(
		.I_pla_312m5_clk (I_pla_312m5_clk),
		.I_pla_rst       (I_pla_rst),
		.lookup          (lookup),
		.fifo_afull      (fifo_afull),
		.store_rsp_resp  (store_rsp.resp),
		.cnt_clear       (cnt_clear),
		.cur_id          (cur_id),
		.store_req       (store_req),
		.rderr_cnt       (rderr_cnt)
	);

	slice_burst_capture u_slice_burst_capture
	(
		.I_pla_312m5_clk (I_pla_312m5_clk),
		.I_pla_rst       (I_pla_rst),
		.store_rsp       (store_rsp),
		.data_rd         (data_rd),
		.fifo_wr         (fifo_wr),
		.fifo_wdata      (fifo_wdata)
	);

	// output side, credit gated
	reflow_out_fifo u_reflow_out_fifo
	(
		.I_pla_312m5_clk (I_pla_312m5_clk),
		.I_pla_rst       (I_pla_rst),
		.fifo_wr         (fifo_wr),
		.fifo_wdata      (fifo_wdata),
		.credit_return   (credit_return),
		.out             (out),
		.fifo_afull      (fifo_afull)
	);

endmodule

// ==== verif/tb_pla_backward_reflow.sv ====
`timescale 1ns/100ps
module tb_pla_backward_reflow;

	localparam int CLK_HALF     = 10;
	localparam int TOTAL_SLICES = 22;
	// all bursts drained at a slow sink rate plus two read timeouts and slack
	localparam int WATCHDOG_NS  = 2 * CLK_HALF *
		(TOTAL_SLICES * pla_reflow_pkg::BURST_WORDS * 8 + 2 * pla_reflow_pkg::READ_TIMEOUT +
		5000);

	logic                           I_pla_312m5_clk;
	logic                           I_pla_rst;
	pla_reflow_bus_pkg::slice_new_t slice_new;
	pla_reflow_bus_pkg::store_rsp_t store_rsp = '0;
	logic                           credit_return = 1'b0;
	logic                           cnt_clear;
	pla_reflow_bus_pkg::store_req_t store_req;
	logic                           data_rd;
	pla_reflow_bus_pkg::out_beat_t  beat;
	pla_reflow_pkg::err_cnt_t       rderr_cnt;

	int data_err = 0;
	int req_err = 0;
	int other_err = 0;
	int unsigned cyc = 0;

	// store model state
	int                         pend_q[$];
	int                         store_phase = 0;
	int                         store_delay = 0;
	int                         serve_id = 0;
	int                         word_idx = 0;
	int                         ignore_id = -1;
	pla_reflow_pkg::data_word_t rd_pipe [pla_reflow_pkg::RD_LATENCY];

	// sink and request monitor state
	pla_reflow_pkg::data_word_t exp_q[$];
	int unsigned                credit_due[$];
	bit                         hold_credits = 1'b0;
	int                         held_credits = 0;
	int                         release_req = 0;
	int                         beat_cnt = 0;
	int                         next_req_id = 0;
	bit                         announced [64];

	pla_backward_reflow UUT
	(
		.I_pla_312m5_clk (I_pla_312m5_clk),
		.I_pla_rst       (I_pla_rst),
		.slice_new       (slice_new),
		.store_rsp       (store_rsp),
		.credit_return   (credit_return),
		.cnt_clear       (cnt_clear),
		.store_req       (store_req),
		.data_rd         (data_rd),
		.out             (beat),
		.rderr_cnt       (rderr_cnt)
	);

	initial
	begin
		I_pla_312m5_clk = 1'b0;
		forever #CLK_HALF I_pla_312m5_clk = ~I_pla_312m5_clk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired at %0t, the run did not finish in time", $time);
		$display("TEST FAIL");
		$finish;
	end

	// word k of a slice as the store returns it
	function automatic pla_reflow_pkg::data_word_t slice_word(input int id, input int k);
		return {4'ha, 12'(id), 16'(k)};
	endfunction

	// --------------------------------------------------
	// store model, sink, request monitor
	// --------------------------------------------------

	task automatic check_requests();
		if (!store_req.req)
			return;
		if (store_req.id >= 64 || !announced[store_req.id])
		begin
			$display("request for id %0d at %0t came before the id was announced",
				store_req.id, $time);
			other_err++;
		end
		if (store_req.id !== pla_reflow_pkg::slice_id_t'(next_req_id))
		begin
			$display("ERR t=%0t store_req.id exp %0d got %0d", $time, next_req_id, store_req.id);
			req_err++;
		end
		next_req_id++;
		if (int'(store_req.id) != ignore_id)
			pend_q.push_back(int'(store_req.id));
	endtask

	task automatic step_store_model();
		store_rsp.rdata = rd_pipe[pla_reflow_pkg::RD_LATENCY-1];
		for (int i = pla_reflow_pkg::RD_LATENCY - 1; i > 0; i--)
			rd_pipe[i] = rd_pipe[i-1];
		rd_pipe[0] = data_rd ? slice_word(serve_id, word_idx) : '0;
		if (data_rd)
			word_idx++;
		case (store_phase)
			0:
			begin
				if (pend_q.size() != 0)
				begin
					serve_id    = pend_q.pop_front();
					store_delay = $urandom_range(1, 6);
					store_phase = 1;
				end
			end
			1:
			begin
				store_delay--;
				if (store_delay == 0)
				begin
					store_rsp.resp = 1'b1;
					word_idx       = 0;
					store_phase    = 2;
				end
			end
			2:
			begin
				store_rsp.resp = 1'b0;
				store_phase    = 3;
			end
			3:
			begin
				if (data_rd)
					store_phase = 4;
			end
			default:
			begin
				// next response only once the burst is over
				if (!data_rd)
					store_phase = 0;
			end
		endcase
	endtask

	task automatic step_sink();
		int unsigned due;
		credit_return = 1'b0;
		if (beat.valid)
		begin
			beat_cnt++;
			held_credits++;
			if (exp_q.size() == 0)
			begin
				$display("unexpected beat %h at %0t", beat.data, $time);
				other_err++;
			end
			else if (beat.data !== exp_q[0])
			begin
				$display("ERR t=%0t out.data exp %h got %h", $time, exp_q[0], beat.data);
				data_err++;
				void'(exp_q.pop_front());
			end
			else
				void'(exp_q.pop_front());
		end
		if (release_req > 0 && held_credits > 0)
		begin
			release_req--;
			held_credits--;
			credit_due.push_back(cyc + 1);
		end
		while (!hold_credits && held_credits > 0)
		begin
			due = cyc + $urandom_range(1, 4);
			if (credit_due.size() != 0 && due < credit_due[$])
				due = credit_due[$];
			credit_due.push_back(due);
			held_credits--;
		end
		if (credit_due.size() != 0 && credit_due[0] <= cyc)
		begin
			credit_return = 1'b1;
			void'(credit_due.pop_front());
		end
	endtask

	always @(negedge I_pla_312m5_clk)
	begin
		cyc++;
		if (!I_pla_rst)
		begin
			check_requests();
			step_sink();
		end
		step_store_model();
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------

	task automatic announce(input int id);
		@(negedge I_pla_312m5_clk);
		slice_new.valid = 1'b1;
		slice_new.id    = pla_reflow_pkg::slice_id_t'(id);
		announced[id]   = 1'b1;
		@(negedge I_pla_312m5_clk);
		slice_new.valid = 1'b0;
	endtask

	task automatic expect_slice(input int id);
		for (int k = 0; k < pla_reflow_pkg::BURST_WORDS; k++)
			exp_q.push_back(slice_word(id, k));
	endtask

	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		while ((exp_q.size() != 0 || credit_due.size() != 0 || held_credits != 0) && n < limit)
		begin
			@(negedge I_pla_312m5_clk);
			n++;
		end
		if (n >= limit)
		begin
			$display("output not drained within %0d cycles, %0d words missing", limit,
				exp_q.size());
			other_err++;
		end
		repeat (10) @(negedge I_pla_312m5_clk);
	endtask

	task automatic check_value(input string name, input int exp, input int got);
		if (exp != got)
		begin
			$display("ERR t=%0t %s exp %0d got %0d", $time, name, exp, got);
			other_err++;
		end
	endtask

	// --------------------------------------------------
	// tests
	// --------------------------------------------------

	task automatic test_in_order();
		for (int id = 0; id < 8; id++)
		begin
			expect_slice(id);
			announce(id);
		end
		wait_drain(8 * pla_reflow_pkg::BURST_WORDS * 8);
	endtask

	task automatic test_out_of_order();
		for (int id = 8; id < 16; id++)
			expect_slice(id);
		for (int id = 15; id >= 8; id--)
		begin
			announce(id);
			repeat ($urandom_range(20, 80)) @(negedge I_pla_312m5_clk);
		end
		wait_drain(8 * pla_reflow_pkg::BURST_WORDS * 8);
	endtask

	task automatic test_credit_hold();
		int base;
		int n;
		base = beat_cnt;
		n = 0;
		hold_credits = 1'b1;
		expect_slice(16);
		expect_slice(17);
		announce(16);
		announce(17);
		while (beat_cnt - base < pla_reflow_pkg::CREDIT_INIT && n < 2000)
		begin
			@(negedge I_pla_312m5_clk);
			n++;
		end
		repeat (60) @(negedge I_pla_312m5_clk);
		check_value("beats_sent", pla_reflow_pkg::CREDIT_INIT, beat_cnt - base);
		// one beat per returned credit
		for (int r = 1; r <= 4; r++)
		begin
			release_req++;
			repeat (12) @(negedge I_pla_312m5_clk);
			check_value("beats_sent", pla_reflow_pkg::CREDIT_INIT + r, beat_cnt - base);
		end
		hold_credits = 1'b0;
		wait_drain(2 * pla_reflow_pkg::BURST_WORDS * 8);
	endtask

	task automatic test_read_timeout();
		ignore_id = 18;
		expect_slice(19);
		announce(18);
		announce(19);
		wait_drain(pla_reflow_pkg::READ_TIMEOUT + 2 * pla_reflow_pkg::BURST_WORDS * 8);
		check_value("rderr_cnt", 1, int'(rderr_cnt));
	endtask

	task automatic test_clear_and_reset();
		int n;
		@(negedge I_pla_312m5_clk);
		cnt_clear = 1'b1;
		@(negedge I_pla_312m5_clk);
		cnt_clear = 1'b0;
		check_value("rderr_cnt", 0, int'(rderr_cnt));
		// another timed-out id, then reset while the next burst streams
		ignore_id = 20;
		expect_slice(21);
		announce(20);
		announce(21);
		n = 0;
		while (!beat.valid && n < pla_reflow_pkg::READ_TIMEOUT + 1000)
		begin
			@(negedge I_pla_312m5_clk);
			n++;
		end
		if (!beat.valid)
		begin
			$display("no output for id 21 within %0d cycles before the reset", n);
			other_err++;
		end
		check_value("rderr_cnt", 1, int'(rderr_cnt));
		check_value("data_rd", 1, int'(data_rd));
		I_pla_rst = 1'b1;
		repeat (5) @(negedge I_pla_312m5_clk);
		check_value("store_req.req", 0, int'(store_req.req));
		check_value("data_rd", 0, int'(data_rd));
		check_value("out.valid", 0, int'(beat.valid));
		check_value("rderr_cnt", 0, int'(rderr_cnt));
		// the cut burst and its credits are gone with the reset
		exp_q.delete();
		credit_due.delete();
		held_credits = 0;
		next_req_id = 0;
		ignore_id   = -1;
		foreach (announced[i])
			announced[i] = 1'b0;
		I_pla_rst = 1'b0;
		// nothing announced, so nothing may move
		repeat (200) @(negedge I_pla_312m5_clk);
		check_value("data_rd", 0, int'(data_rd));
	endtask

	initial
	begin
		int total;
		void'($urandom(92));
		I_pla_rst = 1'b1;
		slice_new = '0;
		cnt_clear = 1'b0;
		foreach (rd_pipe[i])
			rd_pipe[i] = '0;
		repeat (5) @(negedge I_pla_312m5_clk);
		I_pla_rst = 1'b0;
		repeat (5) @(negedge I_pla_312m5_clk);

		test_in_order();
		test_out_of_order();
		test_credit_hold();
		test_read_timeout();
		test_clear_and_reset();

		total = data_err + req_err + other_err;
		$display("errors: data %0d, request %0d, other %0d", data_err, req_err, other_err);
		if (total == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== files.f ====
src/pla_reflow_pkg.sv
src/pla_reflow_bus_pkg.sv
src/slice_valid_table.sv
src/reflow_sequencer.sv
src/slice_burst_capture.sv
src/reflow_out_fifo.sv
src/pla_backward_reflow.sv
verif/tb_pla_backward_reflow.sv

// ==== Makefile ====
TOP := tb_pla_backward_reflow

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module pla_backward_reflow -f files.f

# the log decides pass or fail
sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f files.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
